//--- hw/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    typedef enum logic {
        cmp_beq,
        cmp_bne
    } cmp_op_e;

    typedef enum logic {
        op_b_reg,
        op_b_imm
    } op_b_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_uimm
    } wb_sel_e;

    typedef enum logic [1:0] {
        fwd_regfile,
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_e;

    // travels with the instruction from decode to writeback
    typedef struct packed {
        alu_op_e   alu_op;
        cmp_op_e   cmp_op;
        op_b_sel_e op_b_sel;
        wb_sel_e   wb_sel;
        logic      mem_read;
        logic      mem_write;
        logic      load_regfile;
        logic      is_branch;
        logic      is_jump;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] dest;
        rv32i_word imm;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_NOP = '{
        alu_op:       alu_add,
        cmp_op:       cmp_beq,
        op_b_sel:     op_b_reg,
        wb_sel:       wb_alu,
        mem_read:     1'b0,
        mem_write:    1'b0,
        load_regfile: 1'b0,
        is_branch:    1'b0,
        is_jump:      1'b0,
        rs1:          5'd0,
        rs2:          5'd0,
        dest:         5'd0,
        imm:          32'd0
    };

    // data port request, driven from the memory stage
    typedef struct packed {
        rv32i_word  addr;
        rv32i_word  wdata;
        logic [3:0] mbe;
        logic       read;
        logic       write;
    } mem_req_t;

    // pipeline stage registers
    typedef struct packed {
        rv32i_word pc;
        rv32i_word instr;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  rs1_val;
        rv32i_word  rs2_val;
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  alu_out;
        rv32i_word  store_data;
        logic       br_en;
    } ex_mem_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  result;
        rv32i_word  rdata;
    } mem_wb_t;

endpackage

//--- hw/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  rv32i_pkg::rv32i_word  instr,
    output rv32i_pkg::ctrl_word_t ctrl_word
);

    rv32i_pkg::rv32i_opcode opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv32i_pkg::alu_op_e alu_op;
    logic alu_ok;
    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word s_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word j_imm;

    assign opcode = rv32i_pkg::rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to alu operation, sub only in register form
    always_comb begin
        alu_ok = 1'b1;
        case (funct3)
            3'b000: alu_op = (opcode == rv32i_pkg::op_reg && funct7[5]) ?
                             rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001: alu_op = rv32i_pkg::alu_sll;
            3'b010: alu_op = rv32i_pkg::alu_slt;
            3'b100: alu_op = rv32i_pkg::alu_xor;
            3'b101: begin
                // sra/srai not supported
                alu_op = rv32i_pkg::alu_srl;
                alu_ok = !funct7[5];
            end
            3'b110: alu_op = rv32i_pkg::alu_or;
            3'b111: alu_op = rv32i_pkg::alu_and;
            default: begin
                alu_op = rv32i_pkg::alu_add;
                alu_ok = 1'b0;
            end
        endcase
    end

    // unused source fields stay at x0 so they never trigger a stall
    always_comb begin
        ctrl_word = rv32i_pkg::CTRL_NOP;
        case (opcode)
            rv32i_pkg::op_reg: if (alu_ok) begin
                ctrl_word.alu_op = alu_op;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.rs1 = instr[19:15];
                ctrl_word.rs2 = instr[24:20];
                ctrl_word.dest = instr[11:7];
            end
            rv32i_pkg::op_imm: if (alu_ok) begin
                ctrl_word.alu_op = alu_op;
                ctrl_word.op_b_sel = rv32i_pkg::op_b_imm;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.rs1 = instr[19:15];
                ctrl_word.dest = instr[11:7];
                ctrl_word.imm = i_imm;
            end
            rv32i_pkg::op_lui: begin
                ctrl_word.wb_sel = rv32i_pkg::wb_uimm;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.dest = instr[11:7];
                ctrl_word.imm = u_imm;
            end
            rv32i_pkg::op_load: if (funct3 == 3'b010) begin
                ctrl_word.op_b_sel = rv32i_pkg::op_b_imm;
                ctrl_word.wb_sel = rv32i_pkg::wb_mem;
                ctrl_word.mem_read = 1'b1;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.rs1 = instr[19:15];
                ctrl_word.dest = instr[11:7];
                ctrl_word.imm = i_imm;
            end
            rv32i_pkg::op_store: if (funct3 == 3'b010) begin
                ctrl_word.op_b_sel = rv32i_pkg::op_b_imm;
                ctrl_word.mem_write = 1'b1;
                ctrl_word.rs1 = instr[19:15];
                ctrl_word.rs2 = instr[24:20];
                ctrl_word.imm = s_imm;
            end
            rv32i_pkg::op_br: if (funct3[2:1] == 2'b00) begin
                ctrl_word.cmp_op = funct3[0] ? rv32i_pkg::cmp_bne : rv32i_pkg::cmp_beq;
                ctrl_word.is_branch = 1'b1;
                ctrl_word.rs1 = instr[19:15];
                ctrl_word.rs2 = instr[24:20];
                ctrl_word.imm = b_imm;
            end
            rv32i_pkg::op_jal: begin
                ctrl_word.wb_sel = rv32i_pkg::wb_pc4;
                ctrl_word.is_jump = 1'b1;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.dest = instr[11:7];
                ctrl_word.imm = j_imm;
            end
            default: ;
        endcase
    end

endmodule

//--- hw/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 load,
    input  logic [4:0]           dest,
    input  rv32i_pkg::rv32i_word in_data,
    input  logic [4:0]           src_a,
    input  logic [4:0]           src_b,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);

    rv32i_pkg::rv32i_word regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && dest != 5'd0) begin
            regs[dest] <= in_data;
        end
    end

    // writeback data bypassed to decode in the same cycle
    assign reg_a = (src_a == 5'd0) ? '0 :
                   (load && src_a == dest) ? in_data : regs[src_a];
    assign reg_b = (src_b == 5'd0) ? '0 :
                   (load && src_b == dest) ? in_data : regs[src_b];

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu (
    input  rv32i_pkg::alu_op_e   alu_op,
    input  rv32i_pkg::cmp_op_e   cmp_op,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    output rv32i_pkg::rv32i_word f,
    output logic                 br_en
);

    always_comb begin
        case (alu_op)
            rv32i_pkg::alu_add: f = a + b;
            rv32i_pkg::alu_sub: f = a - b;
            rv32i_pkg::alu_and: f = a & b;
            rv32i_pkg::alu_or:  f = a | b;
            rv32i_pkg::alu_xor: f = a ^ b;
            rv32i_pkg::alu_slt: f = {31'd0, $signed(a) < $signed(b)};
            // shift amount from the low five bits only
            rv32i_pkg::alu_sll: f = a << b[4:0];
            rv32i_pkg::alu_srl: f = a >> b[4:0];
            default:            f = a + b;
        endcase
    end

    // equality compare, flipped for bne
    assign br_en = (a == b) ^ (cmp_op == rv32i_pkg::cmp_bne);

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  rv32i_pkg::ctrl_word_t ctrl_id,
    input  rv32i_pkg::ctrl_word_t ctrl_ex,
    input  rv32i_pkg::ctrl_word_t ctrl_mem,
    input  rv32i_pkg::ctrl_word_t ctrl_wb,
    output rv32i_pkg::fwd_sel_e   fwd_a,
    output rv32i_pkg::fwd_sel_e   fwd_b,
    output logic                  stall
);

    // the younger result in ex/mem wins over mem/wb
    function automatic rv32i_pkg::fwd_sel_e pick_source(
        input logic [4:0]            src,
        input rv32i_pkg::ctrl_word_t mem,
        input rv32i_pkg::ctrl_word_t wb
    );
        if (mem.load_regfile && mem.dest != 5'd0 && mem.dest == src) begin
            return rv32i_pkg::fwd_ex_mem;
        end
        if (wb.load_regfile && wb.dest != 5'd0 && wb.dest == src) begin
            return rv32i_pkg::fwd_mem_wb;
        end
        return rv32i_pkg::fwd_regfile;
    endfunction

    assign fwd_a = pick_source(ctrl_ex.rs1, ctrl_mem, ctrl_wb);
    assign fwd_b = pick_source(ctrl_ex.rs2, ctrl_mem, ctrl_wb);

    // load in execute feeding the instruction in decode
    assign stall = ctrl_ex.mem_read && ctrl_ex.dest != 5'd0 &&
                   (ctrl_ex.dest == ctrl_id.rs1 || ctrl_ex.dest == ctrl_id.rs2);

    // load data is not ready in ex/mem so its consumer must already be held back
    always_comb begin
        assert final (!(ctrl_mem.mem_read &&
                        (fwd_a == rv32i_pkg::fwd_ex_mem || fwd_b == rv32i_pkg::fwd_ex_mem)));
    end

endmodule

//--- hw/datapath.sv
`timescale 1ns/100ps

module datapath #(
    parameter rv32i_pkg::rv32i_word RESET_PC = 32'h0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv32i_pkg::rv32i_word inst_rdata,
    input  logic                 inst_resp,
    output rv32i_pkg::rv32i_word inst_addr,
    output logic                 inst_read,
    input  rv32i_pkg::rv32i_word data_rdata,
    input  logic                 data_resp,
    output rv32i_pkg::rv32i_word data_addr,
    output rv32i_pkg::rv32i_word data_wdata,
    output logic [3:0]           data_mbe,
    output logic                 data_read,
    output logic                 data_write
);

    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::rv32i_word pc_next;
    rv32i_pkg::if_id_t    if_id;
    rv32i_pkg::id_ex_t    id_ex;
    rv32i_pkg::ex_mem_t   ex_mem;
    rv32i_pkg::mem_wb_t   mem_wb;
    rv32i_pkg::ctrl_word_t ctrl_id;
    rv32i_pkg::fwd_sel_e  fwd_a;
    rv32i_pkg::fwd_sel_e  fwd_b;
    rv32i_pkg::mem_req_t  data_req;
    rv32i_pkg::rv32i_word rs1_val;
    rv32i_pkg::rv32i_word rs2_val;
    rv32i_pkg::rv32i_word op_a;
    rv32i_pkg::rv32i_word op_b_reg;
    rv32i_pkg::rv32i_word op_b;
    rv32i_pkg::rv32i_word alu_f;
    rv32i_pkg::rv32i_word mem_result;
    rv32i_pkg::rv32i_word wb_data;
    rv32i_pkg::rv32i_word branch_target;
    rv32i_pkg::rv32i_word rdata_hold;
    logic br_en;
    logic stall;
    logic flush;
    logic load_regs;
    logic data_done;

    control_unit control_unit_inst (
        .instr     (if_id.instr),
        .ctrl_word (ctrl_id)
    );

    regfile regfile_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (mem_wb.ctrl.load_regfile),
        .dest    (mem_wb.ctrl.dest),
        .in_data (wb_data),
        .src_a   (ctrl_id.rs1),
        .src_b   (ctrl_id.rs2),
        .reg_a   (rs1_val),
        .reg_b   (rs2_val)
    );

    alu alu_inst (
        .alu_op (id_ex.ctrl.alu_op),
        .cmp_op (id_ex.ctrl.cmp_op),
        .a      (op_a),
        .b      (op_b),
        .f      (alu_f),
        .br_en  (br_en)
    );

    hazard_unit hazard_unit_inst (
        .ctrl_id  (ctrl_id),
        .ctrl_ex  (id_ex.ctrl),
        .ctrl_mem (ex_mem.ctrl),
        .ctrl_wb  (mem_wb.ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .stall    (stall)
    );

    assign inst_addr = pc;
    assign inst_read = 1'b1;

    // memory stage request, dropped once it has completed under a stall
    assign data_req.addr  = ex_mem.alu_out;
    assign data_req.wdata = ex_mem.store_data;
    assign data_req.read  = ex_mem.ctrl.mem_read && !data_done;
    assign data_req.write = ex_mem.ctrl.mem_write && !data_done;
    assign data_req.mbe   = data_req.write ? 4'hf : 4'h0;

    assign data_addr  = data_req.addr;
    assign data_wdata = data_req.wdata;
    assign data_mbe   = data_req.mbe;
    assign data_read  = data_req.read;
    assign data_write = data_req.write;

    assign load_regs = inst_resp && (!(data_req.read || data_req.write) || data_resp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_done <= 1'b0;
        end else if (load_regs) begin
            data_done <= 1'b0;
        end else if (data_resp && (data_req.read || data_req.write)) begin
            data_done <= 1'b1;
        end
    end

    // load data kept while the fetch side is still waiting
    always_ff @(posedge clk) begin
        if (data_resp && data_req.read) begin
            rdata_hold <= data_rdata;
        end
    end

    // operand forwarding into execute
    always_comb begin
        case (fwd_a)
            rv32i_pkg::fwd_ex_mem: op_a = mem_result;
            rv32i_pkg::fwd_mem_wb: op_a = wb_data;
            default:               op_a = id_ex.rs1_val;
        endcase
        case (fwd_b)
            rv32i_pkg::fwd_ex_mem: op_b_reg = mem_result;
            rv32i_pkg::fwd_mem_wb: op_b_reg = wb_data;
            default:               op_b_reg = id_ex.rs2_val;
        endcase
    end

    assign op_b = (id_ex.ctrl.op_b_sel == rv32i_pkg::op_b_imm) ? id_ex.ctrl.imm : op_b_reg;

    // non-load result of the memory stage, also the ex/mem forward value
    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            rv32i_pkg::wb_pc4:  mem_result = ex_mem.pc + 32'd4;
            rv32i_pkg::wb_uimm: mem_result = ex_mem.ctrl.imm;
            default:            mem_result = ex_mem.alu_out;
        endcase
    end

    assign wb_data = (mem_wb.ctrl.wb_sel == rv32i_pkg::wb_mem) ? mem_wb.rdata : mem_wb.result;

    // branches and jumps resolve in memory
    assign branch_target = ex_mem.pc + ex_mem.ctrl.imm;
    assign flush = (ex_mem.ctrl.is_branch && ex_mem.br_en) || ex_mem.ctrl.is_jump;

    always_comb begin
        if (flush) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= RESET_PC;
            if_id  <= '0;
            id_ex  <= '{ctrl: rv32i_pkg::CTRL_NOP, default: '0};
            ex_mem <= '{ctrl: rv32i_pkg::CTRL_NOP, default: '0};
            mem_wb <= '{ctrl: rv32i_pkg::CTRL_NOP, default: '0};
        end else if (load_regs) begin
            pc <= pc_next;
            // all-zero instruction decodes as nop
            if (flush) begin
                if_id <= '{pc: pc, instr: '0};
            end else if (!stall) begin
                if_id <= '{pc: pc, instr: inst_rdata};
            end
            id_ex <= '{ctrl: (flush || stall) ? rv32i_pkg::CTRL_NOP : ctrl_id,
                       pc: if_id.pc, rs1_val: rs1_val, rs2_val: rs2_val};
            ex_mem <= '{ctrl: flush ? rv32i_pkg::CTRL_NOP : id_ex.ctrl,
                        pc: id_ex.pc, alu_out: alu_f, store_data: op_b_reg,
                        br_en: br_en};
            mem_wb <= '{ctrl: ex_mem.ctrl, result: mem_result,
                        rdata: data_done ? rdata_hold : data_rdata};
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(data_read && data_write));

    // pending request holds until the memory responds
    assert property (@(posedge clk) disable iff (!arst_n)
        (data_read || data_write) && !data_resp |=> $stable(data_req));

endmodule

//--- verification/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);

    int unsigned count;

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        count = 0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // reset held low for RESET_CYCLES edges after power-up or a request
    always @(posedge clk) begin
        if (rst_req) begin
            count <= 0;
            arst_n <= 1'b0;
        end else if (count < RESET_CYCLES - 1) begin
            count <= count + 1;
        end else begin
            arst_n <= 1'b1;
        end
    end

endmodule

//--- verification/mem_model.sv
`timescale 1ns/100ps

module mem_model #(
    parameter logic [31:0] ROM_BASE = 32'h100
) (
    input  logic        clk,
    input  logic        delay_en,
    input  logic [31:0] inst_addr,
    input  logic        inst_read,
    output logic [31:0] inst_rdata,
    output logic        inst_resp,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic [3:0]  data_mbe,
    input  logic        data_read,
    input  logic        data_write,
    output logic [31:0] data_rdata,
    output logic        data_resp,
    output logic        store_fire
);

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic [31:0] rom_index;
    int seed = 32'h3f9e203b;

    initial begin
        inst_resp = 1'b1;
        data_resp = 1'b1;
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0000006f;
        end
        // fill derived from the byte address of each word
        for (int i = 0; i < 256; i++) begin
            ram[i] = (i * 4) * 32'h9e3779b1 + 32'h00c0ffee;
        end
    end

    assign rom_index = (inst_addr - ROM_BASE) >> 2;
    // outside the image the core spins on jal x0, 0
    assign inst_rdata = (inst_read && rom_index < 64) ? rom[rom_index[5:0]] : 32'h0000006f;
    // read data only while a read is requested
    assign data_rdata = data_read ? ram[data_addr[9:2]] : '0;
    assign store_fire = data_write && data_resp && data_mbe == 4'hf;

    always @(posedge clk) begin
        if (delay_en) begin
            inst_resp <= ($random(seed) & 3) != 0;
            data_resp <= ($random(seed) & 3) == 0;
        end else begin
            inst_resp <= 1'b1;
            data_resp <= 1'b1;
        end
        if (store_fire) begin
            ram[data_addr[9:2]] <= data_wdata;
        end
    end

endmodule

//--- verification/tb_datapath.sv
`timescale 1ns/100ps

module tb_datapath;

    localparam logic [31:0] RESET_PC = 32'h100;
    // six tests of at most about 200 cycles each plus margin for random delays
    localparam int TIMEOUT_CYCLES = 4000;

    logic clk;
    logic arst_n;
    logic rst_req = 1'b0;
    logic delay_en = 1'b0;
    logic [31:0] inst_rdata;
    logic inst_resp;
    logic [31:0] inst_addr;
    logic inst_read;
    logic [31:0] data_rdata;
    logic data_resp;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0] data_mbe;
    logic data_read;
    logic data_write;
    logic store_fire;
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;

    clock_gen clock_gen_inst (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    mem_model #(.ROM_BASE(RESET_PC)) mem_model_inst (
        .clk(clk), .delay_en(delay_en),
        .inst_addr(inst_addr), .inst_read(inst_read),
        .inst_rdata(inst_rdata), .inst_resp(inst_resp),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_mbe(data_mbe),
        .data_read(data_read), .data_write(data_write),
        .data_rdata(data_rdata), .data_resp(data_resp), .store_fire(store_fire)
    );

    datapath #(.RESET_PC(RESET_PC)) datapath_inst (
        .clk(clk), .arst_n(arst_n),
        .inst_rdata(inst_rdata), .inst_resp(inst_resp),
        .inst_addr(inst_addr), .inst_read(inst_read),
        .data_rdata(data_rdata), .data_resp(data_resp),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_mbe(data_mbe),
        .data_read(data_read), .data_write(data_write)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
        if (arst_n && store_fire) begin
            got_addr.push_back(data_addr);
            got_data.push_back(data_wdata);
        end
        // byte enables stay clear on a read
        if (arst_n && data_read) begin
            check_value("data_mbe", {28'd0, data_mbe}, 32'd0);
        end
    end

    // instruction encoders, RV32I formats
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [31:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [31:0] imm);
        return itype(imm, rs1, 3'b000, rd, 7'b0010011);
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [31:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] ram_fill(input logic [31:0] addr);
        return addr * 32'h9e3779b1 + 32'h00c0ffee;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // reset the core, load the image, run until the expected stores are logged
    task automatic run_program(input string name, input bit check_reset);
        int start_errors;
        start_errors = errors;
        rst_req <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        rst_req <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_model_inst.rom[i] = (i < prog.size()) ? prog[i] : 32'h0000006f;
        end
        got_addr.delete();
        got_data.delete();
        wait (arst_n == 1'b1);
        @(negedge clk);
        if (check_reset) begin
            check_value("inst_addr", inst_addr, RESET_PC);
            check_value("data_read", {31'd0, data_read}, 32'd0);
            check_value("data_write", {31'd0, data_write}, 32'd0);
        end
        while (got_addr.size() < exp_addr.size()) begin
            @(posedge clk);
        end
        // window for stray stores from squashed instructions
        repeat (20) @(posedge clk);
        check_value("store_count", got_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_value($sformatf("data_addr[%0d]", i), got_addr[i], exp_addr[i]);
            check_value($sformatf("data_wdata[%0d]", i), got_data[i], exp_data[i]);
        end
        if (errors == start_errors) begin
            passed++;
            $display("test %s: ok, %0d stores", name, got_addr.size());
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic test_reset();
        prog.push_back(addi(5'd1, 5'd0, 32'h5a));
        prog.push_back(sw(5'd1, 32'h1f0));
        expect_store(32'h1f0, 32'h5a);
        run_program("reset", 1'b1);
    endtask

    task automatic test_alu(input string name);
        logic [31:0] a;
        logic [31:0] b;
        a = 32'd12;
        b = 32'hfffffffb;
        prog.push_back(addi(5'd1, 5'd0, a));
        prog.push_back(addi(5'd2, 5'd0, b));
        prog.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        prog.push_back(rtype(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));
        prog.push_back(itype(32'd4, 5'd1, 3'b001, 5'd9, 7'b0010011));
        prog.push_back(itype(32'd28, 5'd2, 3'b101, 5'd10, 7'b0010011));
        prog.push_back({20'h12345, 5'd11, 7'b0110111});
        prog.push_back(itype(32'd3, 5'd1, 3'b100, 5'd12, 7'b0010011));
        for (int r = 3; r <= 12; r++) begin
            prog.push_back(sw(r[4:0], (r - 3) * 4));
        end
        expect_store(32'h00, a + b);
        expect_store(32'h04, a - b);
        expect_store(32'h08, a & b);
        expect_store(32'h0c, a | b);
        expect_store(32'h10, a ^ b);
        expect_store(32'h14, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(32'h18, a << 4);
        expect_store(32'h1c, b >> 28);
        expect_store(32'h20, 32'h12345000);
        expect_store(32'h24, a ^ 32'd3);
        run_program(name, 1'b0);
    endtask

    task automatic test_forwarding();
        prog.push_back(addi(5'd1, 5'd0, 32'd3));
        prog.push_back(addi(5'd2, 5'd1, 32'd4));
        prog.push_back(addi(5'd3, 5'd1, 32'd5));
        prog.push_back(addi(5'd4, 5'd1, 32'd6));
        prog.push_back(rtype(7'h00, 5'd2, 5'd4, 3'b000, 5'd5));
        prog.push_back(sw(5'd5, 32'h4c));
        prog.push_back(sw(5'd2, 32'h40));
        prog.push_back(sw(5'd3, 32'h44));
        prog.push_back(sw(5'd4, 32'h48));
        expect_store(32'h4c, 32'd16);
        expect_store(32'h40, 32'd7);
        expect_store(32'h44, 32'd8);
        expect_store(32'h48, 32'd9);
        run_program("forwarding", 1'b0);
    endtask

    task automatic test_load_use();
        prog.push_back(itype(32'h80, 5'd0, 3'b010, 5'd1, 7'b0000011));
        prog.push_back(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        prog.push_back(sw(5'd2, 32'hc0));
        prog.push_back(addi(5'd3, 5'd0, 32'h55));
        prog.push_back(sw(5'd3, 32'h84));
        prog.push_back(itype(32'h84, 5'd0, 3'b010, 5'd4, 7'b0000011));
        prog.push_back(rtype(7'h00, 5'd3, 5'd4, 3'b000, 5'd5));
        prog.push_back(sw(5'd5, 32'hc4));
        expect_store(32'hc0, ram_fill(32'h80) + ram_fill(32'h80));
        expect_store(32'h84, 32'h55);
        expect_store(32'hc4, 32'haa);
        run_program("load_use", 1'b0);
    endtask

    task automatic test_control_flow();
        prog.push_back(addi(5'd1, 5'd0, 32'd1));
        prog.push_back(btype(32'd16, 5'd1, 5'd1, 3'b000));
        prog.push_back(sw(5'd1, 32'h100));
        prog.push_back(sw(5'd1, 32'h104));
        prog.push_back(sw(5'd1, 32'h108));
        prog.push_back(btype(32'd8, 5'd0, 5'd0, 3'b001));
        prog.push_back(addi(5'd2, 5'd0, 32'h22));
        prog.push_back(sw(5'd2, 32'h10c));
        // jal at RESET_PC + 0x20
        prog.push_back(jal(5'd3, 32'd12));
        prog.push_back(sw(5'd0, 32'h110));
        prog.push_back(sw(5'd0, 32'h114));
        prog.push_back(sw(5'd3, 32'h118));
        expect_store(32'h10c, 32'h22);
        expect_store(32'h118, RESET_PC + 32'h20 + 32'd4);
        run_program("control_flow", 1'b0);
    endtask

    initial begin
        test_reset();
        test_alu("alu");
        test_forwarding();
        test_load_use();
        test_control_flow();
        delay_en <= 1'b1;
        test_alu("back_pressure");
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- datapath.f
hw/rv32i_pkg.sv
hw/control_unit.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/datapath.sv
verification/clock_gen.sv
verification/mem_model.sv
verification/tb_datapath.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -sv -f datapath.f \
		--top-module tb_datapath -Mdir obj_dir -o sim_tb_datapath
	./obj_dir/sim_tb_datapath > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
